//--- src.f
source/rx_frontend_pkg.sv
source/cfo_phase_tracker.sv
source/sample_fifo.sv
source/quadrant_derotator.sv
source/rx_frontend.sv
bench/clock_gen.sv
bench/rx_frontend_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= rx_frontend_tb
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG   := Verification passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/rx_frontend_tb.sv
`default_nettype none

module rx_frontend_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FIFO_DEPTH  = 16;
    localparam int DRAIN_LIMIT = 300;

    logic                           clk;
    logic                           reset_n;
    rx_frontend_pkg::sample_t       sample;
    logic                           sample_valid;
    rx_frontend_pkg::cfo_inc_t      cfo_inc;
    logic                           cfo_valid;
    logic                           cfo_manual;
    logic                           out_ready;
    rx_frontend_pkg::sample_t       out_sample;
    rx_frontend_pkg::sample_id_t    out_id;
    logic                           out_valid;
    logic                           overflow;

    integer seed = 32'h9048_e521;
    int     error_count = 0;
    int     check_count = 0;
    int     test_count = 0;

    // reference model state
    rx_frontend_pkg::phase_t        model_freq = '0;
    rx_frontend_pkg::phase_t        model_phase = '0;
    rx_frontend_pkg::sample_id_t    model_id = '0;
    logic                           model_manual = 1'b0;
    rx_frontend_pkg::sample_t       exp_sample_q[$];
    rx_frontend_pkg::sample_id_t    exp_id_q[$];

    // previous cycle of a stalled output
    logic                           held_valid = 1'b0;
    rx_frontend_pkg::sample_t       held_sample;
    rx_frontend_pkg::sample_id_t    held_id;
    rx_frontend_pkg::sample_t       exp_sample;
    rx_frontend_pkg::sample_id_t    exp_id;

    clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(4)) clock_gen_i (
        .clk_o    (clk),
        .reset_no (reset_n)
    );

    rx_frontend rx_frontend_i (
        .clk_i          (clk),
        .reset_ni       (reset_n),
        .sample_i       (sample),
        .sample_valid_i (sample_valid),
        .cfo_inc_i      (cfo_inc),
        .cfo_valid_i    (cfo_valid),
        .cfo_manual_i   (cfo_manual),
        .out_ready_i    (out_ready),
        .out_sample_o   (out_sample),
        .out_id_o       (out_id),
        .out_valid_o    (out_valid),
        .overflow_o     (overflow)
    );

    // --------------------------------------------------
    // checks and reference model
    // --------------------------------------------------
    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual,
                     expected);
        end
    endtask

    function automatic logic [15:0] negate_clip(input logic [15:0] v);
        int n;
        n = $signed(v);
        n = -n;
        if (n > 32767) begin
            n = 32767;
        end
        return n[15:0];
    endfunction

    // rotation rule per quadrant with I in the low half
    function automatic rx_frontend_pkg::sample_t rotate_expected(
        input rx_frontend_pkg::sample_t s, input logic [1:0] q);
        logic [15:0] re;
        logic [15:0] im;
        logic [15:0] new_re;
        logic [15:0] new_im;
        re = s[15:0];
        im = s[31:16];
        case (q)
            2'd0: begin
                new_re = re;
                new_im = im;
            end
            2'd1: begin
                new_re = im;
                new_im = negate_clip(re);
            end
            2'd2: begin
                new_re = negate_clip(re);
                new_im = negate_clip(im);
            end
            default: begin
                new_re = negate_clip(im);
                new_im = re;
            end
        endcase
        return {new_im, new_re};
    endfunction

    // --------------------------------------------------
    // stimulus helpers
    // --------------------------------------------------
    task automatic advance_cycle();
        @(posedge clk);
        #10;
        sample_valid = 1'b0;
        cfo_valid = 1'b0;
    endtask

    task automatic strobe_sample(input rx_frontend_pkg::sample_t s, input bit expect_out);
        rx_frontend_pkg::phase_t phase;
        phase = model_manual ? '0 : model_phase;
        if (expect_out) begin
            exp_sample_q.push_back(rotate_expected(s, phase[19:18]));
            exp_id_q.push_back(model_id);
        end
        // id advances even when the sample gets dropped
        model_id = model_id + 64'd1;
        if (!model_manual) begin
            model_phase = model_phase + model_freq;
        end
        sample = s;
        sample_valid = 1'b1;
    endtask

    task automatic strobe_cfo(input rx_frontend_pkg::cfo_inc_t inc);
        if (!model_manual) begin
            model_freq = model_freq - rx_frontend_pkg::phase_t'(inc);
        end
        cfo_inc = inc;
        cfo_valid = 1'b1;
    endtask

    task automatic send_sample(input rx_frontend_pkg::sample_t s, input bit expect_out);
        strobe_sample(s, expect_out);
        advance_cycle();
    endtask

    task automatic send_cfo(input rx_frontend_pkg::cfo_inc_t inc);
        strobe_cfo(inc);
        advance_cycle();
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (exp_sample_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            advance_cycle();
            cycles++;
        end
        if (exp_sample_q.size() != 0) begin
            error_count++;
            $display("timeout at %0t ns: %0d expected outputs never appeared", $time,
                     exp_sample_q.size());
            exp_sample_q.delete();
            exp_id_q.delete();
        end
        repeat (2) advance_cycle();
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("test %s done, %0d errors", name, error_count - errors_before);
    endtask

    // --------------------------------------------------
    // output monitor sampling midway between edges
    // --------------------------------------------------
    always @(negedge clk) begin
        if (reset_n === 1'b1) begin
            if (held_valid) begin
                check_equal({63'd0, out_valid}, 64'd1, "valid dropped while stalled");
                check_equal({32'd0, out_sample}, {32'd0, held_sample}, "stalled sample");
                check_equal(out_id, held_id, "stalled id");
            end
            held_valid = out_valid && !out_ready;
            held_sample = out_sample;
            held_id = out_id;
            if (out_valid && out_ready) begin
                if (exp_sample_q.size() == 0) begin
                    error_count++;
                    $display("unexpected output at %0t ns with id %0d", $time, out_id);
                end else begin
                    exp_sample = exp_sample_q.pop_front();
                    exp_id = exp_id_q.pop_front();
                    check_equal({32'd0, out_sample}, {32'd0, exp_sample}, "output sample");
                    check_equal(out_id, exp_id, "output id");
                end
            end
        end
    end

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic test_reset_passthrough();
        int errors_before;
        int cycles;
        errors_before = error_count;
        check_equal({63'd0, out_valid}, 64'd0, "out_valid after reset");
        check_equal({63'd0, overflow}, 64'd0, "overflow after reset");
        out_ready = 1'b1;
        strobe_sample($random(seed), 1'b1);
        cycles = 0;
        while (!out_valid && cycles < 20) begin
            advance_cycle();
            cycles++;
        end
        if (!out_valid) begin
            error_count++;
            $display("timeout at %0t ns: no output after a single sample", $time);
        end else begin
            check_equal(64'(cycles), 64'd3, "latency of a single sample");
        end
        wait_for_drain();
        for (int k = 0; k < 8; k++) begin
            send_sample($random(seed), 1'b1);
        end
        wait_for_drain();
        report_test("reset_passthrough", errors_before);
    endtask

    task automatic test_cfo_accumulation();
        int errors_before;
        rx_frontend_pkg::sample_t s;
        errors_before = error_count;
        out_ready = 1'b1;
        send_cfo(-20'sd40000);
        send_cfo(-20'sd25000);
        // enough samples for the phase to wrap
        for (int k = 0; k < 20; k++) begin
            s = $random(seed);
            if (k % 5 == 2) begin
                s[31:16] = 16'h8000;
            end else if (k % 5 == 4) begin
                s[15:0] = 16'h8000;
            end else if (k % 5 == 0) begin
                s = {16'h8000, 16'h8000};
            end
            send_sample(s, 1'b1);
        end
        // sample beside an increment still advances by the old frequency
        // step is large enough to move the next phase into another quadrant
        strobe_sample($random(seed), 1'b1);
        strobe_cfo(20'sd200000);
        advance_cycle();
        for (int k = 0; k < 6; k++) begin
            send_sample($random(seed), 1'b1);
        end
        wait_for_drain();
        report_test("cfo_accumulation", errors_before);
    endtask

    task automatic test_manual_mode();
        int errors_before;
        errors_before = error_count;
        out_ready = 1'b1;
        cfo_manual = 1'b1;
        model_manual = 1'b1;
        model_freq = '0;
        model_phase = '0;
        advance_cycle();
        send_cfo(-20'sd100000);
        for (int k = 0; k < 6; k++) begin
            send_sample($random(seed), 1'b1);
        end
        wait_for_drain();
        cfo_manual = 1'b0;
        model_manual = 1'b0;
        send_cfo(-20'sd70000);
        for (int k = 0; k < 8; k++) begin
            send_sample($random(seed), 1'b1);
        end
        wait_for_drain();
        report_test("manual_mode", errors_before);
    endtask

    task automatic test_backpressure();
        int errors_before;
        int stall;
        errors_before = error_count;
        out_ready = 1'b0;
        for (int k = 0; k < FIFO_DEPTH + 1; k++) begin
            send_sample($random(seed), 1'b1);
        end
        stall = ($unsigned($random(seed)) % 24) + 4;
        repeat (stall) advance_cycle();
        check_equal({63'd0, overflow}, 64'd0, "overflow with a just full FIFO");
        out_ready = 1'b1;
        wait_for_drain();
        report_test("backpressure", errors_before);
    endtask

    task automatic test_overflow();
        int errors_before;
        errors_before = error_count;
        out_ready = 1'b0;
        // the last two samples find the FIFO full
        for (int k = 0; k < FIFO_DEPTH + 3; k++) begin
            send_sample($random(seed), k < FIFO_DEPTH + 1);
        end
        repeat (4) advance_cycle();
        check_equal({63'd0, overflow}, 64'd1, "overflow after dropped samples");
        out_ready = 1'b1;
        wait_for_drain();
        send_sample($random(seed), 1'b1);
        wait_for_drain();
        check_equal({63'd0, overflow}, 64'd1, "overflow is sticky");
        report_test("overflow", errors_before);
    endtask

    initial begin : main
        int cycles;
        sample = '0;
        sample_valid = 1'b0;
        cfo_inc = '0;
        cfo_valid = 1'b0;
        cfo_manual = 1'b0;
        out_ready = 1'b0;
        cycles = 0;
        while (reset_n !== 1'b1 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (reset_n !== 1'b1) begin
            error_count++;
            $display("reset was never released");
        end
        #10;

        test_reset_passthrough();
        test_cfo_accumulation();
        test_manual_mode();
        test_backpressure();
        test_overflow();

        $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic reset_no
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release lines up with the stimulus offset
    initial begin
        reset_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #10 reset_no = 1'b1;
    end

endmodule

`default_nettype wire

//--- source/rx_frontend.sv
`default_nettype none

module rx_frontend (
    input  wire                                 clk_i,
    input  wire                                 reset_ni,

    input  wire rx_frontend_pkg::sample_t       sample_i,
    input  wire                                 sample_valid_i,
    input  wire rx_frontend_pkg::cfo_inc_t      cfo_inc_i,
    input  wire                                 cfo_valid_i,
    input  wire                                 cfo_manual_i,
    input  wire                                 out_ready_i,

    output wire rx_frontend_pkg::sample_t       out_sample_o,
    output wire rx_frontend_pkg::sample_id_t    out_id_o,
    output wire                                 out_valid_o,
    output wire                                 overflow_o
);

    localparam int FIFO_DEPTH = 16;

    // --------------------------------------------------
    // producer to buffer
    // --------------------------------------------------
    wire rx_frontend_pkg::fifo_entry_t  entry;
    wire                                entry_valid;

    // buffer to consumer
    wire rx_frontend_pkg::fifo_entry_t  rd_entry;
    wire                                rd_empty;
    wire                                rd_en;

    cfo_phase_tracker cfo_phase_tracker_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .cfo_inc_i      (cfo_inc_i),
        .cfo_valid_i    (cfo_valid_i),
        .cfo_manual_i   (cfo_manual_i),
        .entry_o        (entry),
        .entry_valid_o  (entry_valid)
    );

    sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) sample_fifo_i (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .wr_entry_i (entry),
        .wr_en_i    (entry_valid),
        .rd_en_i    (rd_en),
        .rd_entry_o (rd_entry),
        .empty_o    (rd_empty),
        .overflow_o (overflow_o)
    );

    quadrant_derotator quadrant_derotator_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .entry_i      (rd_entry),
        .empty_i      (rd_empty),
        .out_ready_i  (out_ready_i),
        .rd_en_o      (rd_en),
        .out_sample_o (out_sample_o),
        .out_id_o     (out_id_o),
        .out_valid_o  (out_valid_o)
    );

endmodule

`default_nettype wire

//--- source/quadrant_derotator.sv
`default_nettype none

module quadrant_derotator (
    input  wire                                 clk_i,
    input  wire                                 reset_ni,

    input  wire rx_frontend_pkg::fifo_entry_t   entry_i,
    input  wire                                 empty_i,
    input  wire                                 out_ready_i,

    output logic                                rd_en_o,
    output rx_frontend_pkg::sample_t            out_sample_o,
    output rx_frontend_pkg::sample_id_t         out_id_o,
    output logic                                out_valid_o
);

    typedef enum logic {
        OUT_EMPTY,
        OUT_FULL
    } out_state_t;

    out_state_t state_q;

    rx_frontend_pkg::iq_t       in_i;
    rx_frontend_pkg::iq_t       in_q;
    rx_frontend_pkg::iq_t       rot_i;
    rx_frontend_pkg::iq_t       rot_q;
    rx_frontend_pkg::quadrant_t quadrant;

    // negation, -32768 clips to 32767
    function automatic rx_frontend_pkg::iq_t neg_sat(input rx_frontend_pkg::iq_t x);
        if (x == rx_frontend_pkg::IQ_MIN) begin
            return rx_frontend_pkg::IQ_MAX;
        end
        return -x;
    endfunction

    // --------------------------------------------------
    // rotation by quadrant
    // --------------------------------------------------
    assign in_i = entry_i[rx_frontend_pkg::ENTRY_SAMPLE_LSB +: rx_frontend_pkg::IQ_W];
    assign in_q = entry_i[rx_frontend_pkg::ENTRY_SAMPLE_LSB + rx_frontend_pkg::IQ_W +:
                          rx_frontend_pkg::IQ_W];
    assign quadrant = entry_i[rx_frontend_pkg::ENTRY_PHASE_LSB + rx_frontend_pkg::PHASE_W
                              - rx_frontend_pkg::QUAD_W +: rx_frontend_pkg::QUAD_W];

    always_comb begin
        case (quadrant)
            2'd1: begin
                rot_i = in_q;
                rot_q = neg_sat(in_i);
            end
            2'd2: begin
                rot_i = neg_sat(in_i);
                rot_q = neg_sat(in_q);
            end
            2'd3: begin
                rot_i = neg_sat(in_q);
                rot_q = in_i;
            end
            default: begin
                rot_i = in_i;
                rot_q = in_q;
            end
        endcase
    end

    // --------------------------------------------------
    // output handshake
    // --------------------------------------------------
    // pop when the register is free or drains this cycle
    assign rd_en_o     = !empty_i && ((state_q == OUT_EMPTY) || out_ready_i);
    assign out_valid_o = (state_q == OUT_FULL);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= OUT_EMPTY;
        end else if (rd_en_o) begin
            state_q <= OUT_FULL;
        end else if (out_ready_i) begin
            state_q <= OUT_EMPTY;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en_o) begin
            out_sample_o <= {rot_q, rot_i};
            out_id_o     <= entry_i[rx_frontend_pkg::ENTRY_ID_LSB +: rx_frontend_pkg::ID_W];
        end
    end

    hold_under_backpressure_a : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        (out_valid_o && !out_ready_i) |=>
            (out_valid_o && $stable(out_sample_o) && $stable(out_id_o))
    ) else $error("output changed while stalled");

endmodule

`default_nettype wire

//--- source/sample_fifo.sv
`default_nettype none

module sample_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire                                 clk_i,
    input  wire                                 reset_ni,

    input  wire rx_frontend_pkg::fifo_entry_t   wr_entry_i,
    input  wire                                 wr_en_i,
    input  wire                                 rd_en_i,

    output rx_frontend_pkg::fifo_entry_t        rd_entry_o,
    output logic                                empty_o,
    output logic                                overflow_o
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    // --------------------------------------------------
    // storage and pointers
    // --------------------------------------------------
    rx_frontend_pkg::fifo_entry_t   mem [FIFO_DEPTH];

    // extra msb tells full from empty
    logic [ADDR_W : 0]              wr_ptr_q;
    logic [ADDR_W : 0]              rd_ptr_q;
    logic                           full;
    logic                           wr_accept;

    assign empty_o   = (wr_ptr_q == rd_ptr_q);
    assign full      = (wr_ptr_q[ADDR_W] != rd_ptr_q[ADDR_W]) &&
                       (wr_ptr_q[ADDR_W - 1 : 0] == rd_ptr_q[ADDR_W - 1 : 0]);
    assign wr_accept = wr_en_i && !full;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr_q <= '0;
        end else if (wr_accept) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    // consumer only pops a non empty FIFO
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rd_ptr_q <= '0;
        end else if (rd_en_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_accept) begin
            mem[wr_ptr_q[ADDR_W - 1 : 0]] <= wr_entry_i;
        end
    end

    // first word fall through
    assign rd_entry_o = mem[rd_ptr_q[ADDR_W - 1 : 0]];

    // --------------------------------------------------
    // sticky overflow
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            overflow_o <= 1'b0;
        end else if (wr_en_i && full) begin
            overflow_o <= 1'b1;
        end
    end

    no_read_when_empty_a : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        rd_en_i |-> !empty_o
    ) else $error("read from empty FIFO");

endmodule

`default_nettype wire

//--- source/cfo_phase_tracker.sv
`default_nettype none

module cfo_phase_tracker (
    input  wire                                 clk_i,
    input  wire                                 reset_ni,

    input  wire rx_frontend_pkg::sample_t       sample_i,
    input  wire                                 sample_valid_i,
    input  wire rx_frontend_pkg::cfo_inc_t      cfo_inc_i,
    input  wire                                 cfo_valid_i,
    input  wire                                 cfo_manual_i,

    output rx_frontend_pkg::fifo_entry_t        entry_o,
    output logic                                entry_valid_o
);

    // --------------------------------------------------
    // counters and accumulators
    // --------------------------------------------------
    rx_frontend_pkg::sample_id_t    sample_cnt_q;
    rx_frontend_pkg::phase_t        freq_q;
    rx_frontend_pkg::phase_t        phase_q;
    rx_frontend_pkg::phase_t        sample_phase;
    rx_frontend_pkg::phase_t        cfo_step;

    // manual mode forces zero phase on the current sample too
    assign sample_phase = cfo_manual_i ? '0 : phase_q;

    // increments are relative, wrap is intended
    assign cfo_step = rx_frontend_pkg::phase_t'(cfo_inc_i);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sample_cnt_q <= '0;
        end else if (sample_valid_i) begin
            sample_cnt_q <= sample_cnt_q + rx_frontend_pkg::sample_id_t'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            freq_q  <= '0;
            phase_q <= '0;
        end else if (cfo_manual_i) begin
            freq_q  <= '0;
            phase_q <= '0;
        end else begin
            if (cfo_valid_i) begin
                freq_q <= freq_q - cfo_step;
            end
            // sample in the same cycle as an increment still sees old F
            if (sample_valid_i) begin
                phase_q <= phase_q + freq_q;
            end
        end
    end

    // --------------------------------------------------
    // entry register
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            entry_valid_o <= 1'b0;
        end else begin
            entry_valid_o <= sample_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            entry_o <= {sample_i, sample_cnt_q, sample_phase};
        end
    end

    // one entry per strobe, one cycle later
    entry_after_strobe_a : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        entry_valid_o |-> $past(sample_valid_i)
    ) else $error("entry_valid_o without sample strobe");

endmodule

`default_nettype wire

//--- source/rx_frontend_pkg.sv
`default_nettype none

package rx_frontend_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int IQ_W     = 16;
    localparam int SAMPLE_W = 2 * IQ_W;
    localparam int PHASE_W  = 20;
    localparam int ID_W     = 64;
    localparam int CFO_W    = 20;
    localparam int QUAD_W   = 2;
    localparam int ENTRY_W  = SAMPLE_W + ID_W + PHASE_W;

    // field positions inside a FIFO entry, sample on top, phase at the bottom
    localparam int ENTRY_PHASE_LSB  = 0;
    localparam int ENTRY_ID_LSB     = PHASE_W;
    localparam int ENTRY_SAMPLE_LSB = PHASE_W + ID_W;

    // --------------------------------------------------
    // vector types
    // --------------------------------------------------
    // one real or imaginary component
    typedef logic signed [IQ_W - 1 : 0] iq_t;

    // Q in the upper half, I in the lower half
    typedef logic [SAMPLE_W - 1 : 0] sample_t;

    // phase and frequency word, quadrant in the top two bits
    typedef logic [PHASE_W - 1 : 0] phase_t;

    // running sample index since reset
    typedef logic [ID_W - 1 : 0] sample_id_t;

    // relative CFO step from the detector
    typedef logic signed [CFO_W - 1 : 0] cfo_inc_t;

    // tagged sample as stored in the buffer
    typedef logic [ENTRY_W - 1 : 0] fifo_entry_t;

    typedef logic [QUAD_W - 1 : 0] quadrant_t;

    // saturation limits of one component
    localparam iq_t IQ_MAX = 16'sh7fff;
    localparam iq_t IQ_MIN = 16'sh8000;

endpackage

`default_nettype wire
